// File: vlog.f
source/ptw_pkg.sv
source/mem_pkg.sv
source/ptw_if.sv
source/ptw_port_arbiter.sv
source/pte_cache.sv
source/ptw_walker.sv
source/ptw_top.sv
tests/ptw_checker.sv
tests/ptw_monitor.sv
tests/ptw_tb.sv

// File: Bender.yml
package:
  name: ptw

sources:
  - source/ptw_pkg.sv
  - source/mem_pkg.sv
  - source/ptw_if.sv
  - source/ptw_port_arbiter.sv
  - source/pte_cache.sv
  - source/ptw_walker.sv
  - source/ptw_top.sv
  - target: test
    files:
      - tests/ptw_checker.sv
      - tests/ptw_monitor.sv
      - tests/ptw_tb.sv

// File: tests/ptw_tb.sv
`default_nettype none

module ptw_tb;
  import ptw_pkg::*;
  import mem_pkg::*;

  localparam int NUM_WALKS   = 24;
  localparam int CYCLE_LIMIT = 400 * NUM_WALKS;
  localparam logic [PPN_W-1:0] ROOT = 44'h100;

  logic                    clk;
  logic                    reset_n;
  logic [PTW_PORT_NUM-1:0] req_valid;
  logic [VPN_W-1:0]        req_vpn      [PTW_PORT_NUM];
  logic [PPN_W-1:0]        req_satp_ppn [PTW_PORT_NUM];
  logic [PTW_PORT_NUM-1:0] req_ready;
  logic [PTW_PORT_NUM-1:0] resp_valid;
  pte_t                    resp_pte     [PTW_PORT_NUM];
  logic [LEVEL_W-1:0]      resp_level   [PTW_PORT_NUM];
  logic [PTW_PORT_NUM-1:0] resp_fault;
  logic                    l2_req_valid;
  l2_cmd_t                 l2_req_cmd;
  logic [PADDR_W-1:0]      l2_req_addr;
  logic [L2_CMD_TAG_W-1:0] l2_req_tag;
  logic                    l2_req_ready;
  logic                    l2_resp_valid;
  logic [L2_CMD_TAG_W-1:0] l2_resp_tag;
  logic [XLEN_W-1:0]       l2_resp_data;

  logic [XLEN_W-1:0]  mem [logic [PADDR_W-1:0]];  // page tables
  logic [PADDR_W-1:0] pend_q [$];
  logic [31:0]        lfsr;
  int                 tb_errors;
  int                 mon_errors;
  int                 cycles;

  ptw_top dut (
    .i_clk (clk), .i_reset_n (reset_n),
    .i_req_valid (req_valid), .i_req_vpn (req_vpn), .i_req_satp_ppn (req_satp_ppn),
    .o_req_ready (req_ready), .o_resp_valid (resp_valid), .o_resp_pte (resp_pte),
    .o_resp_level (resp_level), .o_resp_fault (resp_fault),
    .o_l2_req_valid (l2_req_valid), .o_l2_req_cmd (l2_req_cmd),
    .o_l2_req_addr (l2_req_addr), .o_l2_req_tag (l2_req_tag), .i_l2_req_ready (l2_req_ready),
    .i_l2_resp_valid (l2_resp_valid), .i_l2_resp_tag (l2_resp_tag),
    .i_l2_resp_data (l2_resp_data)
  );

  ptw_monitor u_mon (
    .i_clk (clk), .i_reset_n (reset_n),
    .i_resp_valid (resp_valid), .i_resp_pte (resp_pte), .i_resp_level (resp_level),
    .i_resp_fault (resp_fault), .i_l2_req_valid (l2_req_valid),
    .i_l2_req_ready (l2_req_ready), .i_l2_req_cmd (l2_req_cmd),
    .i_l2_req_addr (l2_req_addr), .i_l2_req_tag (l2_req_tag), .o_err_count (mon_errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [PADDR_W-1:0] entry_addr(input logic [PPN_W-1:0] table_ppn,
                                                     input logic [8:0] idx);
    return {table_ppn, 12'h000} + {idx, 3'b000};
  endfunction

  function automatic logic [63:0] ptr_pte(input logic [PPN_W-1:0] ppn);
    return {10'b0, ppn, 10'h001};  // v only
  endfunction

  function automatic logic [63:0] leaf_pte(input logic [PPN_W-1:0] ppn);
    return {10'b0, ppn, 10'h0cf};  // d a x w r v
  endfunction

  function automatic logic [63:0] mem_rd(input logic [PADDR_W-1:0] a);
    return mem.exists(a) ? mem[a] : 64'h0;
  endfunction

  function automatic void ref_walk(input logic [VPN_W-1:0] vpn, input logic [PPN_W-1:0] satp,
                                   output logic [63:0] pte, output logic [1:0] level,
                                   output logic fault, output logic [PADDR_W-1:0] addrs [3],
                                   output int n);
    logic [PPN_W-1:0] ppn;
    logic             done;
    ppn   = satp;
    level = 2'd2;
    n     = 0;
    done  = 1'b0;
    fault = 1'b0;
    pte   = '0;
    while (!done) begin
      addrs[n] = entry_addr(ppn, vpn[level*9 +: 9]);
      pte      = mem_rd(addrs[n]);
      n++;
      if (!pte[0] || (pte[2] && !pte[1])) begin  // invalid, or w without r
        fault = 1'b1;
        done  = 1'b1;
      end else if (pte[1] || pte[3]) begin
        done = 1'b1;
      end else if (level == 0) begin
        fault = 1'b1;
        done  = 1'b1;
      end else begin
        ppn   = pte[53:10];
        level = level - 1'b1;
      end
    end
  endfunction

  task automatic issue_walk(input int p, input logic [VPN_W-1:0] vpn,
                            input logic [PPN_W-1:0] satp, output time t_acc);
    logic [63:0]        pte;
    logic [1:0]         level;
    logic               fault;
    logic [PADDR_W-1:0] addrs [3];
    int                 n;
    ref_walk(vpn, satp, pte, level, fault, addrs, n);
    @(posedge clk);
    #2;
    req_valid[p]    = 1'b1;
    req_vpn[p]      = vpn;
    req_satp_ppn[p] = satp;
    do @(negedge clk); while (!req_ready[p]);
    t_acc = $time;
    u_mon.expect_walk(p, pte, level, fault, addrs, n);
    @(posedge clk);
    #2;
    req_valid[p] = 1'b0;
  endtask

  task automatic wait_idle();
    do @(negedge clk); while (u_mon.outstanding() != 0);
  endtask

  task automatic build_tables();
    put(ROOT, 1, ptr_pte(44'h200));
    put(44'h200, 2, ptr_pte(44'h300));
    put(44'h300, 3, leaf_pte(44'h12345));
    put(ROOT, 5, leaf_pte(44'h40000));    // gigapage
    put(44'h200, 7, 64'h0000_0000_0000_0005);  // w without r
    put(44'h300, 4, ptr_pte(44'h500));    // pointer at level 0
    for (int a = 0; a < 4; a++) begin
      put(ROOT, 9'(8 + a), ptr_pte(44'h600 + a));
      for (int b = 0; b < 4; b++) begin
        if (b == 3) put(44'h600 + a, 9'(b), leaf_pte(44'h20000 + rand_bits(9)));
        else put(44'h600 + a, 9'(b), ptr_pte(44'h700 + a * 4 + b));
        for (int c = 0; c < 6; c++) begin
          put(44'h700 + a * 4 + b, 9'(c), leaf_pte(44'h80000 + rand_bits(16)));
        end
      end
    end
  endtask

  task automatic put(input logic [PPN_W-1:0] table_ppn, input logic [8:0] idx,
                     input logic [63:0] v);
    mem[entry_addr(table_ppn, idx)] = v;
  endtask

  // l2 side: random ready, responses after 1 to 4 cycles
  always @(posedge clk) begin
    #2 l2_req_ready <= rand_bits(1);
  end

  always @(negedge clk) begin
    if (reset_n && l2_req_valid && l2_req_ready) pend_q.push_back(l2_req_addr);
  end

  initial begin
    logic [PADDR_W-1:0] a;
    int                 d;
    l2_resp_valid = 1'b0;
    l2_resp_tag   = '0;
    l2_resp_data  = '0;
    forever begin
      @(posedge clk);
      if (pend_q.size() != 0) begin
        a = pend_q.pop_front();
        d = 1 + rand_bits(2);
        repeat (d - 1) @(posedge clk);
        if (rand_bits(1)) begin
          #2;
          l2_resp_valid = 1'b1;
          l2_resp_tag   = 8'h40;  // some other requester
          l2_resp_data  = {rand_bits(32), rand_bits(32)};
          @(posedge clk);
        end
        #2;
        l2_resp_valid = 1'b1;
        l2_resp_tag   = PTW_TAG;
        l2_resp_data  = mem_rd(a);
        @(posedge clk);
        #2;
        l2_resp_valid = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, walks did not complete", cycles);
      $display("errors: %0d", tb_errors + mon_errors);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    time t0;
    time t1;
    lfsr            = 32'h360e_0bf4;
    tb_errors       = 0;
    cycles          = 0;
    reset_n         = 1'b0;
    req_valid       = '0;
    req_vpn[0]      = '0;
    req_vpn[1]      = '0;
    req_satp_ppn[0] = '0;
    req_satp_ppn[1] = '0;
    l2_req_ready    = 1'b0;
    build_tables();
    repeat (4) @(posedge clk);
    #2 reset_n = 1'b1;

    issue_walk(0, {9'd1, 9'd2, 9'd3}, ROOT, t0);  // cold, three misses
    wait_idle();
    issue_walk(1, {9'd5, 9'd0, 9'd0}, ROOT, t0);  // gigapage
    wait_idle();
    issue_walk(0, {9'd1, 9'd2, 9'd3}, ROOT, t0);  // all lines cached
    wait_idle();
    issue_walk(1, {9'd6, 9'd0, 9'd0}, ROOT, t0);
    issue_walk(0, {9'd1, 9'd7, 9'd0}, ROOT, t0);
    issue_walk(1, {9'd1, 9'd2, 9'd4}, ROOT, t0);
    wait_idle();

    fork
      issue_walk(0, {9'd1, 9'd2, 9'd3}, ROOT, t0);
      issue_walk(1, {9'd5, 9'd1, 9'd0}, ROOT, t1);
    join
    if (t1 <= t0) begin
      $display("ERR %0t: port 1 accepted no later than port 0", $time);
      tb_errors++;
    end
    wait_idle();

    for (int k = 0; k < 16; k++) begin
      issue_walk(int'(rand_bits(1)),
                 {9'(8 + rand_bits(2)), 9'(rand_bits(2)), 9'(rand_bits(3))}, ROOT, t0);
    end
    wait_idle();

    $display("errors: %0d (monitor %0d, testbench %0d)", tb_errors + mon_errors,
             mon_errors, tb_errors);
    if (tb_errors + mon_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/ptw_monitor.sv
`default_nettype none

module ptw_monitor (
  input  wire logic                              i_clk,
  input  wire logic                              i_reset_n,
  input  wire logic [ptw_pkg::PTW_PORT_NUM-1:0]  i_resp_valid,
  input  wire ptw_pkg::pte_t                     i_resp_pte   [ptw_pkg::PTW_PORT_NUM],
  input  wire logic [ptw_pkg::LEVEL_W-1:0]       i_resp_level [ptw_pkg::PTW_PORT_NUM],
  input  wire logic [ptw_pkg::PTW_PORT_NUM-1:0]  i_resp_fault,
  input  wire logic                              i_l2_req_valid,
  input  wire logic                              i_l2_req_ready,
  input  wire mem_pkg::l2_cmd_t                  i_l2_req_cmd,
  input  wire logic [ptw_pkg::PADDR_W-1:0]       i_l2_req_addr,
  input  wire logic [mem_pkg::L2_CMD_TAG_W-1:0]  i_l2_req_tag,
  output int                                     o_err_count
);
  import ptw_pkg::*;
  import mem_pkg::*;

  logic [66:0]        exp_q0 [$];  // {pte, level, fault}
  logic [66:0]        exp_q1 [$];
  logic [PADDR_W-1:0] l2_q [$];    // reads the cache model says must happen
  logic [7:0]         line_valid;
  logic [49:0]        line_tag [8];

  initial begin
    o_err_count = 0;
    line_valid  = '0;
  end

  // called at acceptance, in acceptance order
  task automatic expect_walk(input int p, input logic [63:0] pte, input logic [1:0] level,
                             input logic fault, input logic [PADDR_W-1:0] addrs [3],
                             input int n);
    logic [2:0]  idx;
    logic [49:0] tag;
    for (int i = 0; i < n; i++) begin
      idx = addrs[i][5:3];
      tag = addrs[i][55:6];
      if (!(line_valid[idx] && line_tag[idx] == tag)) begin
        l2_q.push_back(addrs[i]);
        line_valid[idx] = 1'b1;
        line_tag[idx]   = tag;
      end
    end
    if (p == 0) exp_q0.push_back({pte, level, fault});
    else exp_q1.push_back({pte, level, fault});
  endtask

  function automatic int outstanding();
    return exp_q0.size() + exp_q1.size() + l2_q.size();
  endfunction

  task automatic check_resp(input int p, input logic [66:0] got);
    logic [66:0] want;
    if (p == 0 ? exp_q0.size() == 0 : exp_q1.size() == 0) begin
      $display("response on port %0d with no walk outstanding there", p);
      o_err_count++;
    end else begin
      want = (p == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
      if (got !== want) begin
        $display("ERR %0t: port %0d pte %h lvl %0d fault %0b, want pte %h lvl %0d fault %0b",
                 $time, p, got[66:3], got[2:1], got[0], want[66:3], want[2:1], want[0]);
        o_err_count++;
      end
    end
  endtask

  always @(negedge i_clk) begin
    if (i_reset_n) begin
      for (int p = 0; p < PTW_PORT_NUM; p++) begin
        if (i_resp_valid[p]) check_resp(p, {i_resp_pte[p], i_resp_level[p], i_resp_fault[p]});
      end
      if (i_l2_req_valid && i_l2_req_ready) begin
        if (l2_q.size() == 0) begin
          $display("ERR %0t: unexpected L2 read at %h", $time, i_l2_req_addr);
          o_err_count++;
        end else if (l2_q[0] !== i_l2_req_addr) begin
          $display("ERR %0t: L2 read at %h, want %h", $time, i_l2_req_addr, l2_q[0]);
          o_err_count++;
          void'(l2_q.pop_front());
        end else begin
          void'(l2_q.pop_front());
        end
        if (i_l2_req_cmd !== M_XRD || i_l2_req_tag !== PTW_TAG) begin
          $display("ERR %0t: L2 cmd %h tag %h", $time, i_l2_req_cmd, i_l2_req_tag);
          o_err_count++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/ptw_checker.sv
`default_nettype none

module ptw_checker (
  input wire logic                              i_clk,
  input wire logic                              i_reset_n,
  input wire logic                              i_l2_req_valid,
  input wire logic                              i_l2_req_ready,
  input wire logic [ptw_pkg::PADDR_W-1:0]       i_l2_req_addr,
  input wire logic [ptw_pkg::PTW_PORT_NUM-1:0]  i_resp_valid,
  input wire logic                              i_probe_req,
  input wire logic                              i_probe_resp
);

  default disable iff (!i_reset_n);

  // l2 request must not change or drop while stalled
  a_l2_hold: assert property (@(posedge i_clk)
    i_l2_req_valid && !i_l2_req_ready |=> i_l2_req_valid && $stable(i_l2_req_addr))
    else $error("l2 request changed or dropped before ready");

  a_resp_onehot: assert property (@(posedge i_clk) $onehot0(i_resp_valid))
    else $error("walk response on more than one port");

  a_probe_answer: assert property (@(posedge i_clk) i_probe_req |=> i_probe_resp)
    else $error("cache did not answer one cycle after the probe");

  a_probe_origin: assert property (@(posedge i_clk) i_probe_resp |-> $past(i_probe_req))
    else $error("cache answer without a probe one cycle earlier");

endmodule

bind ptw_walker ptw_checker u_checker (
  .i_clk          (i_clk),
  .i_reset_n      (i_reset_n),
  .i_l2_req_valid (o_l2_req_valid),
  .i_l2_req_ready (i_l2_req_ready),
  .i_l2_req_addr  (o_l2_req_addr),
  .i_resp_valid   ({i_ptw_if[1].resp_valid, i_ptw_if[0].resp_valid}),
  .i_probe_req    (probe.req_valid),
  .i_probe_resp   (probe.resp_valid)
);

`default_nettype wire

// File: source/ptw_top.sv
`default_nettype none

module ptw_top (
  input  wire logic                              i_clk,
  input  wire logic                              i_reset_n,
  input  wire logic [ptw_pkg::PTW_PORT_NUM-1:0]  i_req_valid,
  input  wire logic [ptw_pkg::VPN_W-1:0]         i_req_vpn      [ptw_pkg::PTW_PORT_NUM],
  input  wire logic [ptw_pkg::PPN_W-1:0]         i_req_satp_ppn [ptw_pkg::PTW_PORT_NUM],
  output logic [ptw_pkg::PTW_PORT_NUM-1:0]       o_req_ready,
  output logic [ptw_pkg::PTW_PORT_NUM-1:0]       o_resp_valid,
  output ptw_pkg::pte_t                          o_resp_pte     [ptw_pkg::PTW_PORT_NUM],
  output logic [ptw_pkg::LEVEL_W-1:0]            o_resp_level   [ptw_pkg::PTW_PORT_NUM],
  output logic [ptw_pkg::PTW_PORT_NUM-1:0]       o_resp_fault,
  output logic                                   o_l2_req_valid,
  output mem_pkg::l2_cmd_t                       o_l2_req_cmd,
  output logic [ptw_pkg::PADDR_W-1:0]            o_l2_req_addr,
  output logic [mem_pkg::L2_CMD_TAG_W-1:0]       o_l2_req_tag,
  input  wire logic                              i_l2_req_ready,
  input  wire logic                              i_l2_resp_valid,
  input  wire logic [mem_pkg::L2_CMD_TAG_W-1:0]  i_l2_resp_tag,
  input  wire logic [ptw_pkg::XLEN_W-1:0]        i_l2_resp_data
);
  import ptw_pkg::*;

  logic [PTW_PORT_NUM-1:0] grant_oh;
  ptw_req_t                sel_req;
  logic                    sel_valid;
  logic                    idle;

  tlb_ptw_if   u_ptw_if [PTW_PORT_NUM] ();
  pte_probe_if u_probe ();

  generate
    for (genvar p = 0; p < PTW_PORT_NUM; p++) begin : g_port
      assign u_ptw_if[p].req_valid = i_req_valid[p];
      assign u_ptw_if[p].req       = '{vpn: i_req_vpn[p], satp_ppn: i_req_satp_ppn[p]};
      assign o_req_ready[p]        = u_ptw_if[p].req_ready;
      assign o_resp_valid[p]       = u_ptw_if[p].resp_valid;
      assign o_resp_pte[p]         = u_ptw_if[p].resp_pte;
      assign o_resp_level[p]       = u_ptw_if[p].resp_level;
      assign o_resp_fault[p]       = u_ptw_if[p].resp_fault;
    end
  endgenerate

  ptw_port_arbiter u_arbiter (
    .i_ptw_if    (u_ptw_if),
    .i_idle      (idle),
    .o_grant_oh  (grant_oh),
    .o_sel_req   (sel_req),
    .o_sel_valid (sel_valid)
  );

  pte_cache u_cache (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .probe     (u_probe)
  );

  ptw_walker u_walker (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_ptw_if        (u_ptw_if),
    .i_grant_oh      (grant_oh),
    .i_sel_req       (sel_req),
    .i_sel_valid     (sel_valid),
    .o_idle          (idle),
    .probe           (u_probe),
    .o_l2_req_valid  (o_l2_req_valid),
    .o_l2_req_cmd    (o_l2_req_cmd),
    .o_l2_req_addr   (o_l2_req_addr),
    .o_l2_req_tag    (o_l2_req_tag),
    .i_l2_req_ready  (i_l2_req_ready),
    .i_l2_resp_valid (i_l2_resp_valid),
    .i_l2_resp_tag   (i_l2_resp_tag),
    .i_l2_resp_data  (i_l2_resp_data)
  );

endmodule

`default_nettype wire

// File: source/ptw_walker.sv
`default_nettype none

module ptw_walker (
  input  wire logic                        i_clk,
  input  wire logic                        i_reset_n,
  tlb_ptw_if.walker                        i_ptw_if [ptw_pkg::PTW_PORT_NUM],
  input  wire logic [ptw_pkg::PTW_PORT_NUM-1:0] i_grant_oh,
  input  wire ptw_pkg::ptw_req_t           i_sel_req,
  input  wire logic                        i_sel_valid,
  output logic                             o_idle,
  pte_probe_if.walker                      probe,
  output logic                             o_l2_req_valid,
  output mem_pkg::l2_cmd_t                 o_l2_req_cmd,
  output logic [ptw_pkg::PADDR_W-1:0]      o_l2_req_addr,
  output logic [mem_pkg::L2_CMD_TAG_W-1:0] o_l2_req_tag,
  input  wire logic                        i_l2_req_ready,
  input  wire logic                        i_l2_resp_valid,
  input  wire logic [mem_pkg::L2_CMD_TAG_W-1:0] i_l2_resp_tag,
  input  wire logic [ptw_pkg::XLEN_W-1:0]  i_l2_resp_data
);
  import ptw_pkg::*;
  import mem_pkg::*;

  typedef enum logic [2:0] {
    IDLE         = 3'd0,
    PROBE        = 3'd1,
    PROBE_RESP   = 3'd2,
    L2_REQUEST   = 3'd3,
    L2_RESP_WAIT = 3'd4
  } state_t;

  state_t                  r_state;
  logic [LEVEL_W-1:0]      r_level;
  logic [PTW_PORT_NUM-1:0] r_grant_oh;
  logic [VPN_W-1:0]        r_vpn;
  logic [PADDR_W-1:0]      r_addr;

  pte_t pte;
  logic l2_match;
  logic pte_arrived;
  logic is_leaf;
  logic bad_pte;
  logic last_level;
  logic walk_done;
  logic walk_fault;

  // table base plus vpn field of the level, 8-byte entries
  function automatic logic [PADDR_W-1:0] pte_addr(input logic [PPN_W-1:0]   ppn,
                                                  input logic [VPN_W-1:0]   vpn,
                                                  input logic [LEVEL_W-1:0] level);
    logic [VPN_FIELD_W-1:0] field;
    field = vpn[level*VPN_FIELD_W +: VPN_FIELD_W];
    return {ppn, {PG_IDX_W{1'b0}}} +
           PADDR_W'({field, {$clog2(XLEN_W / 8){1'b0}}});
  endfunction

  assign l2_match = (r_state == L2_RESP_WAIT) & i_l2_resp_valid & (i_l2_resp_tag == PTW_TAG);

  assign pte_arrived = ((r_state == PROBE_RESP) & probe.resp_valid & probe.hit) | l2_match;

  assign pte = (r_state == L2_RESP_WAIT) ? pte_t'(i_l2_resp_data) : probe.data;

  assign is_leaf    = pte.v & (pte.r | pte.x);
  assign bad_pte    = ~pte.v | (pte.w & ~pte.r);
  assign last_level = (r_level == '0);
  assign walk_done  = is_leaf | bad_pte | last_level;
  assign walk_fault = bad_pte | (~is_leaf & last_level);  // pointer at level 0

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state    <= IDLE;
      r_level    <= '0;
      r_grant_oh <= '0;
    end else begin
      case (r_state)
        IDLE: begin
          if (i_sel_valid) begin
            r_state    <= PROBE;
            r_level    <= LEVEL_W'(PG_LEVELS - 1);
            r_grant_oh <= i_grant_oh;
          end
        end
        PROBE: r_state <= PROBE_RESP;
        PROBE_RESP: begin
          if (!probe.hit) begin
            r_state <= L2_REQUEST;
          end else begin
            r_state <= walk_done ? IDLE : PROBE;
            if (!walk_done) r_level <= r_level - 1'b1;
          end
        end
        L2_REQUEST: begin
          if (i_l2_req_ready) r_state <= L2_RESP_WAIT;
        end
        L2_RESP_WAIT: begin
          if (l2_match) begin
            r_state <= walk_done ? IDLE : PROBE;
            if (!walk_done) r_level <= r_level - 1'b1;
          end
        end
        default: r_state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if ((r_state == IDLE) && i_sel_valid) begin
      r_vpn  <= i_sel_req.vpn;
      r_addr <= pte_addr(i_sel_req.satp_ppn, i_sel_req.vpn, LEVEL_W'(PG_LEVELS - 1));
    end else if (pte_arrived && !walk_done) begin
      r_addr <= pte_addr(pte.ppn, r_vpn, r_level - 1'b1);  // next level table
    end
  end

  assign o_idle = (r_state == IDLE);

  assign probe.req_valid  = (r_state == PROBE);
  assign probe.paddr      = r_addr;
  assign probe.fill_valid = l2_match;
  assign probe.fill_addr  = r_addr;
  assign probe.fill_data  = i_l2_resp_data;

  generate
    for (genvar p = 0; p < PTW_PORT_NUM; p++) begin : g_resp
      assign i_ptw_if[p].resp_valid = pte_arrived & walk_done & r_grant_oh[p];
      assign i_ptw_if[p].resp_pte   = pte;
      assign i_ptw_if[p].resp_level = r_level;
      assign i_ptw_if[p].resp_fault = walk_fault;
    end
  endgenerate

  // request held while in L2_REQUEST
  assign o_l2_req_valid = (r_state == L2_REQUEST);
  assign o_l2_req_cmd   = M_XRD;
  assign o_l2_req_addr  = r_addr;
  assign o_l2_req_tag   = PTW_TAG;

endmodule

`default_nettype wire

// File: source/pte_cache.sv
`default_nettype none

module pte_cache (
  input wire logic    i_clk,
  input wire logic    i_reset_n,
  pte_probe_if.cache  probe
);
  import ptw_pkg::*;

  localparam int CACHE_LINES = 8;
  localparam int IDX_W       = $clog2(CACHE_LINES);
  localparam int OFS_W       = $clog2(XLEN_W / 8);   // one pte per line
  localparam int TAG_LSB     = IDX_W + OFS_W;
  localparam int TAG_W       = PADDR_W - TAG_LSB;

  logic [CACHE_LINES-1:0] r_valid;
  logic [TAG_W-1:0]       r_tag  [CACHE_LINES];
  pte_t                   r_data [CACHE_LINES];

  logic [IDX_W-1:0] probe_idx;
  logic [TAG_W-1:0] probe_tag;
  logic [IDX_W-1:0] fill_idx;
  logic [TAG_W-1:0] fill_tag;
  logic             tag_match;

  assign probe_idx = probe.paddr[OFS_W +: IDX_W];
  assign probe_tag = probe.paddr[PADDR_W-1:TAG_LSB];
  assign fill_idx  = probe.fill_addr[OFS_W +: IDX_W];
  assign fill_tag  = probe.fill_addr[PADDR_W-1:TAG_LSB];

  assign tag_match = r_valid[probe_idx] & (r_tag[probe_idx] == probe_tag);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid          <= '0;
      probe.resp_valid <= 1'b0;
      probe.hit        <= 1'b0;
    end else begin
      if (probe.fill_valid) begin
        r_valid[fill_idx] <= 1'b1;
      end
      // answer lands one cycle after the probe
      probe.resp_valid <= probe.req_valid;
      probe.hit        <= probe.req_valid & tag_match;
    end
  end

  always_ff @(posedge i_clk) begin
    if (probe.fill_valid) begin
      r_tag[fill_idx]  <= fill_tag;
      r_data[fill_idx] <= pte_t'(probe.fill_data);
    end
    if (probe.req_valid) begin
      probe.data <= r_data[probe_idx];  // only meaningful with hit
    end
  end

endmodule

`default_nettype wire

// File: source/ptw_port_arbiter.sv
`default_nettype none

module ptw_port_arbiter (
  tlb_ptw_if.requester                     i_ptw_if [ptw_pkg::PTW_PORT_NUM],
  input  wire logic                        i_idle,
  output logic [ptw_pkg::PTW_PORT_NUM-1:0] o_grant_oh,
  output ptw_pkg::ptw_req_t                o_sel_req,
  output logic                             o_sel_valid
);
  import ptw_pkg::*;

  logic [PTW_PORT_NUM-1:0] req_valid;
  ptw_req_t                req [PTW_PORT_NUM];

  generate
    for (genvar p = 0; p < PTW_PORT_NUM; p++) begin : g_port
      assign req_valid[p] = i_ptw_if[p].req_valid;
      assign req[p]       = i_ptw_if[p].req;
      assign i_ptw_if[p].req_ready = i_idle & o_grant_oh[p];
    end
  endgenerate

  // lowest valid index wins, so port 0 takes ties
  assign o_grant_oh  = req_valid & (~req_valid + 1'b1);
  assign o_sel_valid = |req_valid;

  always_comb begin
    o_sel_req = '0;
    for (int p = 0; p < PTW_PORT_NUM; p++) begin
      if (o_grant_oh[p]) begin
        o_sel_req = ptw_req_t'(o_sel_req | req[p]);
      end
    end
  end

endmodule

`default_nettype wire

// File: source/ptw_if.sv
`default_nettype none

// one per tlb, translation request and walk result
interface tlb_ptw_if;
  import ptw_pkg::*;

  logic               req_valid;
  ptw_req_t           req;
  logic               req_ready;  // single cycle accept pulse
  logic               resp_valid;
  pte_t               resp_pte;
  logic [LEVEL_W-1:0] resp_level;
  logic               resp_fault;

  // request half, served by the arbiter
  modport requester (input req_valid, req, output req_ready);

  modport walker (output resp_valid, resp_pte, resp_level, resp_fault);
endinterface

// walker side lookup into the pte cache, plus fill from l2
interface pte_probe_if;
  import ptw_pkg::*;

  logic               req_valid;
  logic [PADDR_W-1:0] paddr;
  logic               resp_valid;
  logic               hit;
  pte_t               data;
  logic               fill_valid;
  logic [PADDR_W-1:0] fill_addr;
  logic [XLEN_W-1:0]  fill_data;

  modport walker (output req_valid, paddr, fill_valid, fill_addr, fill_data,
                  input resp_valid, hit, data);
  modport cache (input req_valid, paddr, fill_valid, fill_addr, fill_data,
                 output resp_valid, hit, data);
endinterface

`default_nettype wire

// File: source/mem_pkg.sv
`default_nettype none

package mem_pkg;

  localparam int L2_CMD_TAG_W = 8;

  // requester code in the top two tag bits
  localparam logic [1:0] L2_UPPER_TAG_PTW = 2'b11;

  localparam logic [L2_CMD_TAG_W-1:0] PTW_TAG = {L2_UPPER_TAG_PTW, {(L2_CMD_TAG_W-2){1'b0}}};

  typedef enum logic [4:0] {
    M_XRD = 5'b00000,  // int load
    M_XWR = 5'b00001,  // int store
    M_PFR = 5'b00010,  // prefetch read
    M_PFW = 5'b00011   // prefetch write
  } l2_cmd_t;

endpackage

`default_nettype wire

// File: source/ptw_pkg.sv
`default_nettype none

package ptw_pkg;

  localparam int XLEN_W       = 64;
  localparam int PG_LEVELS    = 3;   // sv39
  localparam int VPN_FIELD_W  = 9;
  localparam int VPN_W        = 27;
  localparam int PPN_W        = 44;
  localparam int PADDR_W      = 56;
  localparam int PG_IDX_W     = 12;
  localparam int LEVEL_W      = 2;
  localparam int PTW_PORT_NUM = 2;   // itlb, dtlb

  typedef struct packed {
    logic [9:0]       reserved;
    logic [PPN_W-1:0] ppn;
    logic [1:0]       rsw;
    logic             d;
    logic             a;
    logic             g;
    logic             u;
    logic             x;
    logic             w;
    logic             r;
    logic             v;
  } pte_t;

  typedef struct packed {
    logic [VPN_W-1:0] vpn;
    logic [PPN_W-1:0] satp_ppn;  // root table of the requester
  } ptw_req_t;

endpackage

`default_nettype wire
